//--- rtl/cpuPkg.sv
package cpuPkg;

	localparam int wordW = 16;
	localparam int opW = 5;
	localparam int regSelW = 3;
	localparam int numRegs = 8;
	localparam int immW = 8;
	localparam int labelW = 11;
	localparam int imemDepth = 64;
	localparam int dmemDepth = 64;
	localparam int memAddrW = 6;
	localparam logic [memAddrW-1:0] spReset = 6'd63; // stack grows down from the top

	// opcodes, msb set means branch
	localparam logic [opW-1:0] opPush = 5'b00000;
	localparam logic [opW-1:0] opPop  = 5'b00001;
	localparam logic [opW-1:0] opAdd  = 5'b00010;
	localparam logic [opW-1:0] opOr   = 5'b00011;
	localparam logic [opW-1:0] opNot  = 5'b00100;
	localparam logic [opW-1:0] opNeg  = 5'b00101;
	localparam logic [opW-1:0] opInc  = 5'b00110;
	localparam logic [opW-1:0] opDec  = 5'b00111;
	localparam logic [opW-1:0] opCall = 5'b01000;
	localparam logic [opW-1:0] opRet  = 5'b01001;
	localparam logic [opW-1:0] opLdi  = 5'b01010;

	// branch condition codes, low four opcode bits
	localparam logic [3:0] ccAlways = 4'd0;
	localparam logic [3:0] ccZ  = 4'd1;
	localparam logic [3:0] ccNz = 4'd2;
	localparam logic [3:0] ccC  = 4'd3;
	localparam logic [3:0] ccNc = 4'd4;
	localparam logic [3:0] ccS  = 4'd5;
	localparam logic [3:0] ccNs = 4'd6;
	localparam logic [3:0] ccV  = 4'd7;
	localparam logic [3:0] ccNv = 4'd8;

	typedef enum logic [2:0] {passX, add, orOp, notX, negX, incX, decX} aluFunc_e;
	typedef enum logic [1:0] {next, label, stack} pcSel_e;

	typedef union packed {
		struct packed {
			logic [opW-1:0] opcode;
			logic [regSelW-1:0] rSel;
			logic [immW-1:0] imm;
		} regForm;
		struct packed {
			logic [opW-1:0] opcode;
			logic [labelW-1:0] target; // branch or call destination
		} labelForm;
	} instr_u;

	typedef struct packed {
		logic z;
		logic c;
		logic s;
		logic v;
	} flags_s;

endpackage

//--- rtl/ctrlIf.sv
`timescale 1ns/1ps

interface ctrlIf import cpuPkg::*; ();
	logic ldReg;
	logic ldPc;
	logic ldSp;
	logic ldFlag;
	logic memWe;
	logic spUp;         // pop and ret move sp toward the top
	logic regFromStack;
	logic regFromImm;
	aluFunc_e aluFunc;
	pcSel_e pcSel;
	logic [3:0] cond;

	modport ctrl (
		output ldReg, ldPc, ldSp, ldFlag, memWe, spUp,
		output regFromStack, regFromImm, aluFunc, pcSel, cond
	);

	modport exec (
		input ldReg, ldPc, ldSp, ldFlag, memWe, spUp,
		input regFromStack, regFromImm, aluFunc, pcSel, cond
	);

endinterface

//--- rtl/controller.sv
`timescale 1ns/1ps

module controller import cpuPkg::*; (
	input  logic ldSig,
	input  logic resetN,
	input  logic run,
	input  instr_u instr,
	input  logic condTrue,
	ctrlIf.ctrl cb,
	output logic isCall
);
	logic phase;
	logic fire;
	logic [opW-1:0] op;
	logic isBranch;
	logic isPush;
	logic isPop;
	logic isRet;
	logic isLdi;
	logic isAlu;
	aluFunc_e aluSel;

	assign op = instr.regForm.opcode;
	assign isBranch = op[opW-1];
	assign fire = phase & run; // commit phase only

	// 0 decode, 1 commit
	always_ff @(posedge ldSig or negedge resetN) begin
		if (!resetN)
			phase <= 1'b0;
		else if (run)
			phase <= ~phase;
	end

	always_comb begin
		isPush = 1'b0;
		isPop = 1'b0;
		isCall = 1'b0;
		isRet = 1'b0;
		isLdi = 1'b0;
		aluSel = passX;
		case (op)
			opPush: isPush = 1'b1;
			opPop:  isPop = 1'b1;
			opAdd:  aluSel = add;
			opOr:   aluSel = orOp;
			opNot:  aluSel = notX;
			opNeg:  aluSel = negX;
			opInc:  aluSel = incX;
			opDec:  aluSel = decX;
			opCall: isCall = 1'b1;
			opRet:  isRet = 1'b1;
			opLdi:  isLdi = 1'b1;
			default: ; // no-op or branch
		endcase
	end

	assign isAlu = (aluSel != passX);

	assign cb.ldReg = fire & (isPop | isAlu | isLdi);
	assign cb.ldFlag = fire & isAlu;
	assign cb.ldPc = fire;
	assign cb.ldSp = fire & (isPush | isPop | isCall | isRet);
	assign cb.memWe = fire & (isPush | isCall);
	assign cb.spUp = isPop | isRet;
	assign cb.regFromStack = isPop;
	assign cb.regFromImm = isLdi;
	assign cb.aluFunc = aluSel;
	assign cb.cond = op[3:0];

	always_comb begin
		if (isCall || (isBranch && condTrue))
			cb.pcSel = label;
		else if (isRet)
			cb.pcSel = stack;
		else
			cb.pcSel = next;
	end

endmodule

//--- rtl/regBank.sv
`timescale 1ns/1ps

module regBank import cpuPkg::*; (
	input  logic ldSig,
	input  logic resetN,
	input  instr_u instr,
	input  logic [wordW-1:0] aluZ,
	input  logic [wordW-1:0] stackTop,
	ctrlIf.exec cb,
	output logic [wordW-1:0] regOut
);
	logic [regSelW-1:0] rSel;
	logic [wordW-1:0] wData;
	logic [wordW-1:0] regQ [numRegs];

	assign rSel = instr.regForm.rSel;

	// pop value, zero-extended immediate or alu result
	assign wData = cb.regFromStack ? stackTop :
		cb.regFromImm ? {{(wordW-immW){1'b0}}, instr.regForm.imm} : aluZ;

	for (genvar i = 0; i < numRegs; i++) begin : gReg
		logic [wordW-1:0] q;
		logic we;

		assign we = cb.ldReg && (rSel == i);

		always_ff @(posedge ldSig or negedge resetN) begin
			if (!resetN)
				q <= '0;
			else if (we)
				q <= wData;
		end

		assign regQ[i] = q;
	end

	assign regOut = regQ[rSel]; // same field picks the read

endmodule

//--- rtl/alu.sv
`timescale 1ns/1ps

module alu import cpuPkg::*; (
	input  logic [wordW-1:0] x,
	input  logic [wordW-1:0] y,
	ctrlIf.exec cb,
	output logic [wordW-1:0] z,
	output logic carry,
	output logic overflow
);
	logic [wordW-1:0] opA;
	logic [wordW-1:0] opB;
	logic cin;
	logic isSub;
	logic [wordW:0] sum;
	logic [wordW-1:0] lowSum; // top bit is the carry into the msb

	// every arithmetic op runs through one adder
	always_comb begin
		opA = x;
		opB = y;
		cin = 1'b0;
		isSub = 1'b0;
		case (cb.aluFunc)
			incX: begin
				opB = '0;
				cin = 1'b1;
			end
			decX: begin
				opB = '1; // x + (-1)
				isSub = 1'b1;
			end
			negX: begin
				opA = '0;
				opB = ~x;
				cin = 1'b1;
				isSub = 1'b1;
			end
			default: ;
		endcase
		sum = {1'b0, opA} + {1'b0, opB} + {{wordW{1'b0}}, cin};
		lowSum = {1'b0, opA[wordW-2:0]} + {1'b0, opB[wordW-2:0]} + {{(wordW-1){1'b0}}, cin};
	end

	always_comb begin
		carry = 1'b0;
		overflow = 1'b0;
		case (cb.aluFunc)
			add, incX, decX, negX: begin
				z = sum[wordW-1:0];
				carry = sum[wordW] ^ isSub; // borrow for the subtracting ops
				overflow = lowSum[wordW-1] ^ sum[wordW];
			end
			orOp: z = x | y;
			notX: z = ~x;
			default: z = x;
		endcase
	end

endmodule

//--- rtl/flagUnit.sv
`timescale 1ns/1ps

module flagUnit import cpuPkg::*; (
	input  logic ldSig,
	input  logic resetN,
	input  logic [wordW-1:0] z,
	input  logic carry,
	input  logic overflow,
	ctrlIf.exec cb,
	output logic condTrue,
	output flags_s flags
);

	always_ff @(posedge ldSig or negedge resetN) begin
		if (!resetN) begin
			flags <= '0;
		end else if (cb.ldFlag) begin
			flags.z <= (z == '0);
			flags.c <= carry;
			flags.s <= z[wordW-1];
			flags.v <= overflow;
		end
	end

	always_comb begin
		case (cb.cond)
			ccAlways: condTrue = 1'b1;
			ccZ:      condTrue = flags.z;
			ccNz:     condTrue = !flags.z;
			ccC:      condTrue = flags.c;
			ccNc:     condTrue = !flags.c;
			ccS:      condTrue = flags.s;
			ccNs:     condTrue = !flags.s;
			ccV:      condTrue = flags.v;
			ccNv:     condTrue = !flags.v;
			default:  condTrue = 1'b0; // unused codes never branch
		endcase
	end

endmodule

//--- rtl/fetchUnit.sv
`timescale 1ns/1ps

module fetchUnit import cpuPkg::*; (
	input  logic ldSig,
	input  logic resetN,
	input  logic progWe,
	input  logic [memAddrW-1:0] progAddr,
	input  logic [wordW-1:0] progData,
	ctrlIf.exec cb,
	input  logic [wordW-1:0] stackTop,
	output instr_u instr,
	output logic [wordW-1:0] pc,
	output logic [wordW-1:0] pcNext1
);
	logic [wordW-1:0] imem [imemDepth];
	logic [wordW-1:0] target;

	// program load port
	always_ff @(posedge ldSig) begin
		if (progWe)
			imem[progAddr] <= progData;
	end

	assign instr = imem[pc[memAddrW-1:0]]; // async read
	assign pcNext1 = pc + 1'b1;
	assign target = {{(wordW-labelW){1'b0}}, instr.labelForm.target};

	always_ff @(posedge ldSig or negedge resetN) begin
		if (!resetN) begin
			pc <= '0;
		end else if (cb.ldPc) begin
			case (cb.pcSel)
				label:   pc <= target;
				stack:   pc <= stackTop; // return address
				default: pc <= pcNext1;
			endcase
		end
	end

endmodule

//--- rtl/stackMem.sv
`timescale 1ns/1ps

module stackMem import cpuPkg::*; (
	input  logic ldSig,
	input  logic resetN,
	ctrlIf.exec cb,
	input  logic [wordW-1:0] regOut,
	input  logic [wordW-1:0] pcNext1,
	input  logic isCall,
	output logic [wordW-1:0] stackTop,
	output logic [memAddrW-1:0] memAddr,
	output logic [wordW-1:0] memWdata,
	output logic memWe
);
	logic [memAddrW-1:0] sp;
	logic [memAddrW-1:0] spPlus;
	logic [memAddrW-1:0] spMinus;
	logic [wordW-1:0] dmem [dmemDepth];

	// sp is the next free word, top of stack sits just above it
	assign spPlus = sp + 1'b1;
	assign spMinus = sp - 1'b1;

	assign memAddr = sp;
	assign memWdata = isCall ? pcNext1 : regOut; // return address on call
	assign memWe = cb.memWe;

	always_ff @(posedge ldSig) begin
		if (memWe)
			dmem[sp] <= memWdata;
	end

	assign stackTop = dmem[spPlus];

	always_ff @(posedge ldSig or negedge resetN) begin
		if (!resetN)
			sp <= spReset;
		else if (cb.ldSp)
			sp <= cb.spUp ? spPlus : spMinus;
	end

endmodule

//--- rtl/cpuTop.sv
`timescale 1ns/1ps

module cpuTop import cpuPkg::*; (
	input  logic ldSig,
	input  logic resetN,
	input  logic run,
	input  logic progWe,
	input  logic [memAddrW-1:0] progAddr,
	input  logic [wordW-1:0] progData,
	output logic [wordW-1:0] pc,
	output logic memWe,
	output logic [memAddrW-1:0] memAddr,
	output logic [wordW-1:0] memWdata,
	output flags_s flags
);
	instr_u instr;
	logic condTrue;
	logic isCall;
	logic [wordW-1:0] regOut;
	logic [wordW-1:0] stackTop;
	logic [wordW-1:0] aluZ;
	logic [wordW-1:0] pcNext1;
	logic aluCarry;
	logic aluOverflow;

	ctrlIf cb ();

	controller uCtrl (
		.ldSig, .resetN, .run, .instr, .condTrue,
		.cb(cb.ctrl),
		.isCall
	);

	regBank uRegs (
		.ldSig, .resetN, .instr, .aluZ, .stackTop,
		.cb(cb.exec),
		.regOut
	);

	// top of stack is x, selected register is y
	alu uAlu (
		.x(stackTop), .y(regOut), .cb(cb.exec),
		.z(aluZ), .carry(aluCarry), .overflow(aluOverflow)
	);

	flagUnit uFlags (
		.ldSig, .resetN, .z(aluZ), .carry(aluCarry), .overflow(aluOverflow),
		.cb(cb.exec), .condTrue, .flags
	);

	fetchUnit uFetch (
		.ldSig, .resetN, .progWe, .progAddr, .progData,
		.cb(cb.exec), .stackTop, .instr, .pc, .pcNext1
	);

	stackMem uStack (
		.ldSig, .resetN, .cb(cb.exec), .regOut, .pcNext1, .isCall,
		.stackTop, .memAddr, .memWdata, .memWe
	);

endmodule

//--- test/cpuTop_chk.sv
`timescale 1ns/1ps

module portChecks import cpuPkg::*; (
	input logic ldSig,
	input logic resetN,
	input logic run,
	input logic [wordW-1:0] pc,
	input logic memWe
);
	int failCount = 0;

	// one write strobe per instruction
	noDoubleWe: assert property (@(posedge ldSig) disable iff (!resetN) memWe |=> !memWe)
		else begin
			failCount++;
			$error("memWe high on two consecutive cycles");
		end

	pcSettles: assert property (@(posedge ldSig) disable iff (!resetN)
		!$stable(pc) |=> $stable(pc))
		else begin
			failCount++;
			$error("pc changed on two consecutive cycles");
		end

	weQuietStopped: assert property (@(posedge ldSig) !run |-> !memWe)
		else begin
			failCount++;
			$error("memWe high while run is low");
		end

	pcQuietStopped: assert property (@(posedge ldSig) disable iff (!resetN)
		!run |=> $stable(pc))
		else begin
			failCount++;
			$error("pc moved while run is low");
		end

	quietInReset: assert property (@(posedge ldSig) !resetN |=> (pc == '0 && !memWe))
		else begin
			failCount++;
			$error("pc or memWe active during reset");
		end

endmodule

bind cpuTop portChecks chk0 (.ldSig, .resetN, .run, .pc, .memWe);

//--- test/cpuTb.sv
`timescale 1ns/1ps

module cpuTb import cpuPkg::*; ();
	logic ldSig = 1'b0;
	logic resetN, run, progWe;
	logic [memAddrW-1:0] progAddr;
	logic [wordW-1:0] progData;
	logic [wordW-1:0] pc;
	logic memWe;
	logic [memAddrW-1:0] memAddr;
	logic [wordW-1:0] memWdata;
	flags_s flags;

	// reference model state
	logic [wordW-1:0] prog [imemDepth];
	logic [wordW-1:0] mReg [numRegs];
	logic [wordW-1:0] mMem [dmemDepth];
	logic [wordW-1:0] mPc;
	logic [memAddrW-1:0] mSp;
	logic [3:0] mFlags; // z c s v
	logic mPhase;
	logic weExp;
	logic [wordW-1:0] curWord;
	logic [wordW-1:0] wdExp;
	int seed;
	int progLen;
	int haltAddr;
	int errCount;
	int timeoutCount;
	int total;

	cpuTop dut0 (.*);

	always #20 ldSig = ~ldSig;

	function automatic logic [wordW-1:0] encodeReg(logic [opW-1:0] op, int r,
		logic [immW-1:0] imm);
		return {op, r[regSelW-1:0], imm};
	endfunction

	function automatic logic [wordW-1:0] encodeLabel(logic [opW-1:0] op, int target);
		return {op, target[labelW-1:0]};
	endfunction

	function automatic logic [immW-1:0] randomImm();
		int r;
		r = $random(seed);
		return r[immW-1:0];
	endfunction

	function automatic logic condHolds(logic [3:0] cc, logic [3:0] f);
		case (cc)
			ccAlways: return 1'b1;
			ccZ: return f[3];
			ccNz: return !f[3];
			ccC: return f[2];
			ccNc: return !f[2];
			ccS: return f[1];
			ccNs: return !f[1];
			ccV: return f[0];
			ccNv: return !f[0];
			default: return 1'b0;
		endcase
	endfunction

	// returns {carry, overflow, result}
	function automatic logic [wordW+1:0] aluRef(logic [opW-1:0] op, logic [wordW-1:0] x,
		logic [wordW-1:0] y);
		logic [wordW:0] wide;
		logic [wordW-1:0] res;
		logic c;
		logic v;
		c = 1'b0;
		v = 1'b0;
		wide = {1'b0, x} + {1'b0, y};
		case (op)
			opAdd: begin
				res = wide[wordW-1:0];
				c = wide[wordW];
				v = (x[15] == y[15]) && (res[15] != x[15]); // signed overflow
			end
			opOr: res = x | y;
			opNot: res = ~x;
			opNeg: begin
				res = -x;
				c = (x != 0); // borrow of 0 - x
				v = (x == 16'h8000);
			end
			opInc: begin
				res = x + 1'b1;
				c = (x == 16'hffff);
				v = (x == 16'h7fff);
			end
			default: begin
				res = x - 1'b1;
				c = (x == 0);
				v = (x == 16'h8000);
			end
		endcase
		return {c, v, res};
	endfunction

	task automatic reportMismatch(string what, logic [wordW-1:0] got, logic [wordW-1:0] exp);
		errCount++;
		$display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
	endtask

	task automatic addWord(logic [wordW-1:0] w);
		prog[progLen] = w;
		progLen++;
	endtask

	task automatic buildProgram();
		logic [opW-1:0] aluOps [6];
		logic [3:0] ccs [12];
		aluOps = '{opAdd, opOr, opNot, opNeg, opInc, opDec};
		ccs = '{ccZ, ccNz, ccC, ccNc, ccS, ccNs, ccV, ccNv, ccAlways, 4'd9, 4'd15, ccZ};
		progLen = 0;
		for (int r = 1; r <= 2; r++) begin
			addWord(encodeReg(opLdi, r, randomImm()));
			addWord(encodeReg(opPush, r, 8'h00));
		end
		for (int i = 0; i < 6; i++) begin
			addWord(encodeReg(opLdi, 3, randomImm()));
			addWord(encodeReg(aluOps[i], 3, 8'h00));
			addWord(encodeReg(opPush, 3, 8'h00));
			for (int j = 0; j < 2; j++) begin
				addWord(encodeLabel({1'b1, ccs[2*i+j]}, progLen + 2)); // skips the no-op
				addWord(encodeReg(5'b01111, 0, 8'h00));
			end
		end
		addWord(encodeReg(opPop, 5, 8'h00));
		addWord(encodeReg(opPush, 5, 8'h00));
		addWord(encodeLabel(opCall, progLen + 2));
		haltAddr = progLen;
		addWord(encodeLabel({1'b1, ccAlways}, progLen)); // spin here
		addWord(encodeReg(opLdi, 6, randomImm()));
		addWord(encodeReg(opRet, 0, 8'h00));
	endtask

	task automatic stepModel();
		logic [wordW-1:0] w;
		logic [wordW-1:0] top;
		logic [wordW+1:0] r;
		logic [regSelW-1:0] rs;
		w = prog[mPc[memAddrW-1:0]];
		rs = w[10:8];
		top = mMem[mSp + 1'b1];
		mPc = mPc + 1'b1;
		if (w[15]) begin
			if (condHolds(w[14:11], mFlags))
				mPc = w[10:0];
		end else begin
			case (w[15:11])
				opPush: begin
					mMem[mSp] = mReg[rs];
					mSp = mSp - 1'b1;
				end
				opPop: begin
					mReg[rs] = top;
					mSp = mSp + 1'b1;
				end
				opLdi: mReg[rs] = {8'h00, w[7:0]};
				opCall: begin
					mMem[mSp] = mPc;
					mSp = mSp - 1'b1;
					mPc = w[10:0];
				end
				opRet: begin
					mPc = top;
					mSp = mSp + 1'b1;
				end
				opAdd, opOr, opNot, opNeg, opInc, opDec: begin
					r = aluRef(w[15:11], top, mReg[rs]);
					mReg[rs] = r[15:0];
					mFlags = {r[15:0] == 16'h0000, r[17], r[15], r[16]};
				end
				default: ;
			endcase
		end
	endtask

	// outputs settle between edges
	always @(negedge ldSig) begin
		if (!resetN) begin
			mPc = '0;
			mSp = spReset;
			mFlags = '0;
			mPhase = 1'b0;
			mReg = '{default: '0};
		end
		curWord = prog[mPc[memAddrW-1:0]];
		weExp = resetN && run && mPhase && (curWord[15:11] inside {opPush, opCall});
		wdExp = (curWord[15:11] == opCall) ? mPc + 1'b1 : mReg[curWord[10:8]];
		assert (pc === mPc) else reportMismatch("pc", pc, mPc);
		assert (memWe === weExp) else reportMismatch("memWe", memWe, weExp);
		assert (flags === mFlags) else reportMismatch("flags", flags, mFlags);
		if (weExp) begin
			assert (memAddr === mSp) else reportMismatch("memAddr", memAddr, mSp);
			assert (memWdata === wdExp) else reportMismatch("memWdata", memWdata, wdExp);
		end
		if (resetN && run) begin
			if (mPhase)
				stepModel();
			mPhase = !mPhase;
		end
	end

	task automatic loadProgram();
		for (int a = 0; a < progLen; a++) begin
			progWe <= 1'b1;
			progAddr <= memAddrW'(a);
			progData <= prog[a];
			@(posedge ldSig);
		end
		progWe <= 1'b0;
	endtask

	task automatic waitForPc(int target, int limit);
		int n;
		n = 0;
		do begin
			@(negedge ldSig);
			n++;
		end while (pc !== target[wordW-1:0] && n < limit);
		if (pc !== target[wordW-1:0]) begin
			timeoutCount++;
			$display("timeout: pc did not reach %0d within %0d cycles", target, limit);
		end
		@(posedge ldSig);
	endtask

	initial begin
		seed = 48246;
		errCount = 0;
		timeoutCount = 0;
		resetN = 1'b0;
		run = 1'b0;
		progWe = 1'b0;
		progAddr = '0;
		progData = '0;
		buildProgram();
		repeat (10) @(posedge ldSig);
		resetN <= 1'b1;
		loadProgram();
		run <= 1'b1;
		waitForPc(6, 40); // freeze in the commit phase of a push
		run <= 1'b0;
		repeat (6) @(posedge ldSig);
		run <= 1'b1;
		waitForPc(haltAddr, 300);
		repeat (4) @(posedge ldSig);
		total = errCount + timeoutCount + dut0.chk0.failCount;
		$display("value errors %0d, timeouts %0d, assertion failures %0d",
			errCount, timeoutCount, dut0.chk0.failCount);
		if (total == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

//--- filelist.f
rtl/cpuPkg.sv
rtl/ctrlIf.sv
rtl/controller.sv
rtl/regBank.sv
rtl/alu.sv
rtl/flagUnit.sv
rtl/fetchUnit.sv
rtl/stackMem.sv
rtl/cpuTop.sv
test/cpuTop_chk.sv
test/cpuTb.sv

//--- Bender.yml
package:
  name: cpu16

sources:
  - rtl/cpuPkg.sv
  - rtl/ctrlIf.sv
  - rtl/controller.sv
  - rtl/regBank.sv
  - rtl/alu.sv
  - rtl/flagUnit.sv
  - rtl/fetchUnit.sv
  - rtl/stackMem.sv
  - rtl/cpuTop.sv
  - target: test
    files:
      - test/cpuTop_chk.sv
      - test/cpuTb.sv
